// File: adder_tree/adder_tree.sv
`timescale 1ns/1ps

module adder_tree
  import fir_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  product_vec_t products,  // 21 registered products
  output acc_t         sum        // full sum, 4 cycles later
);

  // shape is fixed for 21 inputs: 10 -> 5 -> 2 -> 1
  localparam int LVL_A_N = 10;
  localparam int LVL_B_N = 5;
  localparam int LVL_C_N = 2;

  acc_t lvl_a [LVL_A_N];  // pair sums, last one takes three
  acc_t lvl_b [LVL_B_N];  // pairs of level a
  acc_t lvl_c [LVL_C_N];  // second one takes three
  acc_t lvl_d;            // final sum

  ////////////////////
  // level a
  ////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < LVL_A_N; i++) begin
        lvl_a[i] <= '0;
      end
    end else begin
      for (int i = 0; i < LVL_A_N - 1; i++) begin
        lvl_a[i] <= products[2*i] + products[2*i+1];  // products 0..17
      end
      // odd leftover folded in here
      lvl_a[LVL_A_N-1] <= products[18] + products[19] + products[20];
    end
  end

  ////////////////////
  // level b
  ////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < LVL_B_N; i++) begin
        lvl_b[i] <= '0;
      end
    end else begin
      for (int i = 0; i < LVL_B_N; i++) begin
        lvl_b[i] <= lvl_a[2*i] + lvl_a[2*i+1];  // 10 -> 5, even split
      end
    end
  end

  ////////////////////
  // level c
  ////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < LVL_C_N; i++) begin
        lvl_c[i] <= '0;
      end
    end else begin
      lvl_c[0] <= lvl_b[0] + lvl_b[1];
      lvl_c[1] <= lvl_b[2] + lvl_b[3] + lvl_b[4];  // odd one folded in
    end
  end

  ////////////////////
  // level d
  ////////////////////

  // all levels stay at 24b, the default set cannot overflow it
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lvl_d <= '0;
    end else begin
      lvl_d <= lvl_c[0] + lvl_c[1];  // sfix24_En22
    end
  end

  assign sum = lvl_d;

endmodule

// File: common/fir_pkg.sv
package fir_pkg;

  ////////////////////
  // filter geometry
  ////////////////////

  localparam int NUM_TAPS = 21;  // symmetric, odd length
  localparam int SAMPLE_W = 14;  // sfix14_En13
  localparam int COEFF_W  = 10;  // sfix10_En9
  localparam int ACC_W    = 24;  // sfix24_En22, products and partial sums
  localparam int OUT_LSB  = 9;   // drops 9 fraction bits, En22 -> En13

  ////////////////////
  // scalar types
  ////////////////////

  typedef logic signed [SAMPLE_W-1:0] sample_t;  // one input or output sample
  typedef logic signed [COEFF_W-1:0]  coeff_t;   // one filter coefficient
  typedef logic signed [ACC_W-1:0]    acc_t;     // product or partial sum

  ////////////////////
  // per-tap vectors
  ////////////////////

  // index 0 is the newest sample, element 0 sits at the left end
  typedef sample_t [0:NUM_TAPS-1] tap_vec_t;      // 294 bits
  typedef coeff_t  [0:NUM_TAPS-1] coeff_vec_t;    // 210 bits
  typedef acc_t    [0:NUM_TAPS-1] product_vec_t;  // 504 bits

  // lowpass-ish set in tap order, sums to zero so dc is rejected
  localparam coeff_vec_t DEFAULT_COEFFS = '{
    coeff_t'(-19),  // tap 0
    coeff_t'(-3),
    coeff_t'(8),
    coeff_t'(-2),
    coeff_t'(8),
    coeff_t'(48),
    coeff_t'(24),
    coeff_t'(-82),
    coeff_t'(-101),
    coeff_t'(45),
    coeff_t'(148),  // centre tap
    coeff_t'(45),
    coeff_t'(-101),
    coeff_t'(-82),
    coeff_t'(24),
    coeff_t'(48),
    coeff_t'(8),
    coeff_t'(-2),
    coeff_t'(8),
    coeff_t'(-3),
    coeff_t'(-19)   // tap 20
  };

endpackage

// File: logic/coeff_multiplier_bank.sv
`timescale 1ns/1ps

module coeff_multiplier_bank
  import fir_pkg::*;
#(
  parameter coeff_vec_t COEFFS = DEFAULT_COEFFS  // tap order
) (
  input  logic         clk,
  input  logic         reset,
  input  tap_vec_t     taps,      // from delay line
  output product_vec_t products   // registered, one per tap
);

  ////////////////////
  // product registers
  ////////////////////

  product_vec_t products_q;  // sfix24_En22 each

  // 14b x 10b fits in 24b exactly, so no product ever wraps
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      products_q <= '0;
    end else begin
      for (int i = 0; i < NUM_TAPS; i++) begin
        // widen both sides first, keeps the multiply signed at full width
        products_q[i] <= acc_t'(taps[i]) * acc_t'(COEFFS[i]);
      end
    end
  end
  // runs every cycle, the enable only gates the two ends of the pipe

  assign products = products_q;

endmodule

// File: logic/fir_filter.sv
`timescale 1ns/1ps

module fir_filter
  import fir_pkg::*;
#(
  parameter coeff_vec_t COEFFS = DEFAULT_COEFFS  // passed down to multipliers
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    clk_enable,  // sample strobe, plain level
  input  sample_t sample_in,   // sfix14_En13
  output sample_t sample_out   // sfix14_En13, 7 cycles later
);

  ////////////////////
  // internal wires
  ////////////////////

  tap_vec_t     taps;      // delay line window
  product_vec_t products;  // one per tap
  acc_t         sum;       // tree result

  ////////////////////
  // pipeline
  ////////////////////

  // edge k: sample into tap 0
  tap_delay_line u_tap_delay_line (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .sample_in  (sample_in),
    .taps       (taps)
  );

  // edge k+1: products
  coeff_multiplier_bank #(
    .COEFFS (COEFFS)
  ) u_coeff_multiplier_bank (
    .clk      (clk),
    .reset    (reset),
    .taps     (taps),
    .products (products)
  );

  // edges k+2 .. k+5: levels a to d
  adder_tree u_adder_tree (
    .clk      (clk),
    .reset    (reset),
    .products (products),
    .sum      (sum)
  );

  // edge k+6 staging, k+7 output
  output_quantizer u_output_quantizer (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .sum        (sum),
    .sample_out (sample_out)
  );

endmodule

// File: logic/output_quantizer.sv
`timescale 1ns/1ps

module output_quantizer
  import fir_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    clk_enable,  // gates the output register only
  input  acc_t    sum,         // sfix24_En22 from tree
  output sample_t sample_out   // sfix14_En13
);

  localparam int OUT_MSB = OUT_LSB + SAMPLE_W - 1;  // bit 22

  sample_t staged_q;  // free running stage
  sample_t out_q;     // enabled output

  ////////////////////
  // staging register
  ////////////////////

  // plain bit slice: floor by 512, top bit of sum dropped so it wraps
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      staged_q <= '0;
    end else begin
      staged_q <= sum[OUT_MSB:OUT_LSB];  // runs every cycle
    end
  end

  ////////////////////
  // output register
  ////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      out_q <= '0;
    end else if (clk_enable) begin
      out_q <= staged_q;  // holds while enable low
    end
  end

  assign sample_out = out_q;

endmodule

// File: logic/tap_delay_line.sv
`timescale 1ns/1ps

module tap_delay_line
  import fir_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     clk_enable,  // level, shift only while high
  input  sample_t  sample_in,   // newest sample
  output tap_vec_t taps         // taps[0] newest, taps[20] oldest
);

  ////////////////////
  // shift register
  ////////////////////

  tap_vec_t taps_q;  // delay line storage

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      taps_q <= '0;  // empty window
    end else if (clk_enable) begin
      taps_q[0] <= sample_in;  // new sample in
      for (int i = 1; i < NUM_TAPS; i++) begin
        taps_q[i] <= taps_q[i-1];  // age by one
      end
    end
    // no enable: window holds
  end

  assign taps = taps_q;

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the FIR filter testbench with Verilator.
set -e

cd "$(dirname "$0")"

LOG=sim_run.log
BIN=fir_filter_tb_sim

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f verilog.f --top-module fir_filter_tb -o "$BIN"

./obj_dir/"$BIN" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "All tests passed!" "$LOG"; then
  echo "simulation result: pass"
  exit 0
else
  echo "simulation result: fail"
  exit 1
fi

// File: sim/fir_tb_model.svh
`ifndef FIR_TB_MODEL_SVH
`define FIR_TB_MODEL_SVH

////////////////////
// stimulus lfsr
////////////////////

logic [31:0] lfsr_state = 32'he1b3;  // fixed seed

// galois form, taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  if (s[0]) begin
    return (s >> 1) ^ 32'h80200003;
  end
  return s >> 1;
endfunction

task automatic draw_sample(output sample_t s);
  for (int b = 0; b < SAMPLE_W; b++) begin
    s[b] = lfsr_state[0];                // one step per bit
    lfsr_state = lfsr_next(lfsr_state);
  end
endtask

////////////////////
// reference model
////////////////////

localparam int MODEL_LAT = 7;  // edges from tap 0 to sample_out

sample_t model_hist [NUM_TAPS] = '{default: '0};   // enabled samples, 0 newest
sample_t model_pipe [MODEL_LAT] = '{default: '0};  // one window result per cycle
sample_t exp_out = '0;                             // expected sample_out

// full-precision dot product, then floor by 512 and wrap to 14 bits
function automatic sample_t window_result();
  int full;
  full = 0;
  for (int i = 0; i < NUM_TAPS; i++) begin
    full += int'(model_hist[i]) * int'(DEFAULT_COEFFS[i]);
  end
  return sample_t'(full >>> OUT_LSB);
endfunction

task automatic model_clear();
  for (int i = 0; i < NUM_TAPS; i++) begin
    model_hist[i] = '0;
  end
  for (int i = 0; i < MODEL_LAT; i++) begin
    model_pipe[i] = '0;
  end
  exp_out = '0;
endtask

task automatic model_step(input logic en, input sample_t smp);
  if (en) begin
    for (int i = NUM_TAPS - 1; i > 0; i--) begin
      model_hist[i] = model_hist[i-1];  // history moves on enabled edges only
    end
    model_hist[0] = smp;
    exp_out = model_pipe[MODEL_LAT-1];  // window seen 7 edges back
  end
  for (int i = MODEL_LAT - 1; i > 0; i--) begin
    model_pipe[i] = model_pipe[i-1];    // inner stages run every cycle
  end
  model_pipe[0] = window_result();
endtask

`endif

// File: sim/fir_filter_tb.sv
`timescale 1ns/1ps

module fir_filter_tb
  import fir_pkg::*;
;

  localparam int RESET_CYCLES = 16;
  localparam int LATENCY      = 7;
  localparam int WATCHDOG_NS  = 20000;  // whole run, well above need

  logic    clk = 1'b0;
  logic    reset;
  logic    clk_enable;
  sample_t sample_in;
  sample_t sample_out;

  int check_errs   = 0;  // continuous model compare
  int hold_errs    = 0;  // enable hold property
  int test_errs    = 0;  // in-test checks
  int tests_passed = 0;
  int tests_failed = 0;

  `include "fir_tb_model.svh"

  fir_filter #(
    .COEFFS (DEFAULT_COEFFS)
  ) uut (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .sample_in  (sample_in),
    .sample_out (sample_out)
  );

  initial begin
    forever #2 clk = ~clk;  // 4 ns period
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout, simulation did not reach the end of the tests");
    $display("Test failures found");
    $finish;
  end

  ////////////////////
  // model and checks
  ////////////////////

  always @(posedge clk) begin
    if (reset) begin
      model_clear();
    end else begin
      model_step(clk_enable, sample_in);  // inputs settled since negedge
    end
  end

  always @(negedge clk) begin
    assert (sample_out == exp_out) else begin
      $display("FAILED sample_out=%h expected=%h at %0t", sample_out, exp_out, $time);
      check_errs++;
    end
  end

  // a disabled edge must leave the output untouched
  hold_check: assert property (@(posedge clk) disable iff (reset)
      !$past(clk_enable) |-> (sample_out == $past(sample_out)))
    else begin
      $display("sample_out changed on an edge with clk_enable low at %0t", $time);
      hold_errs++;
    end

  function automatic int total_errors();
    return check_errs + hold_errs + test_errs;
  endfunction

  task automatic check_value(input sample_t got, input sample_t want);
    assert (got == want) else begin
      $display("FAILED sample_out=%h expected=%h at %0t", got, want, $time);
      test_errs++;
    end
  endtask

  task automatic run_cycles(input int n);
    for (int c = 0; c < n; c++) begin
      @(negedge clk);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (total_errors() == errs_before) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, total_errors() - errs_before);
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    int      errs_start;
    sample_t rnd;
    sample_t held;

    reset      = 1'b1;
    clk_enable = 1'b0;
    sample_in  = '0;

    // reset state, then the empty pipe drains zeros
    errs_start = total_errors();
    for (int c = 0; c < RESET_CYCLES; c++) begin
      @(negedge clk);
      check_value(sample_out, '0);
    end
    reset      = 1'b0;
    clk_enable = 1'b1;
    for (int c = 0; c < LATENCY; c++) begin
      @(negedge clk);
      check_value(sample_out, '0);
    end
    report_test("reset state", errs_start);

    // 0.5 impulse gives 4096 * c / 512 = 8 * c per tap
    errs_start = total_errors();
    sample_in = sample_t'(4096);
    @(negedge clk);
    sample_in = '0;
    run_cycles(LATENCY);
    for (int i = 0; i < NUM_TAPS; i++) begin
      check_value(sample_out, sample_t'(8 * int'(DEFAULT_COEFFS[i])));
      @(negedge clk);
    end
    for (int c = 0; c < 5; c++) begin
      check_value(sample_out, '0);  // back to rest
      @(negedge clk);
    end
    report_test("impulse response", errs_start);

    // constant input, full window plus latency before the check
    errs_start = total_errors();
    for (int c = 0; c < 40; c++) begin
      sample_in = sample_t'(1000);
      if (c >= NUM_TAPS + LATENCY) begin
        check_value(sample_out, exp_out);
      end
      @(negedge clk);
    end
    sample_in = '0;
    report_test("dc rejection", errs_start);

    // free stream, checked every cycle by the model compare
    errs_start = total_errors();
    for (int c = 0; c < 300; c++) begin
      draw_sample(rnd);
      sample_in = rnd;
      @(negedge clk);
    end
    report_test("random stream", errs_start);

    // enable dropped mid stream, samples offered meanwhile are ignored
    errs_start = total_errors();
    for (int c = 0; c < 30; c++) begin
      draw_sample(rnd);
      sample_in = rnd;
      @(negedge clk);
    end
    clk_enable = 1'b0;
    held = exp_out;  // model value from last enabled edge
    for (int c = 0; c < 12; c++) begin
      draw_sample(rnd);
      sample_in = rnd;
      @(negedge clk);
      check_value(sample_out, held);
    end
    clk_enable = 1'b1;
    for (int c = 0; c < 30 + LATENCY; c++) begin
      draw_sample(rnd);
      sample_in = rnd;
      @(negedge clk);
    end
    report_test("enable hold", errs_start);

    sample_in = '0;
    run_cycles(LATENCY);
    @(posedge clk);  // last negedge compare has run
    $display("tests: %0d passed, %0d failed, %0d errors",
             tests_passed, tests_failed, total_errors());
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+sim
common/fir_pkg.sv
logic/tap_delay_line.sv
logic/coeff_multiplier_bank.sv
adder_tree/adder_tree.sv
logic/output_quantizer.sv
logic/fir_filter.sv
sim/fir_filter_tb.sv
